// ==== dv/icache_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module icache_tb
    import mem_bus_pkg::*;
();

    localparam int TIMEOUT_CYCLES = 40;
    localparam int MISS_CYCLES    = MEM_LATENCY_CYCLES + 2;   // address to fetch_valid

    logic                     clock;
    logic                     reset;
    logic                     squash;
    logic [XLEN-1:0]          fetch_addr;
    logic                     load_enable;
    logic [MEM_WORD_BITS-1:0] load_addr;
    logic [63:0]              load_data;
    logic [63:0]              fetch_data;
    logic                     fetch_valid;

    logic [63:0] ref_mem [MEM_WORDS];   // reference copy of the backing store
    logic [31:0] lcg_state;
    int          errors;
    int          checks;
    int          tests_run;

    icache_top icache_top_inst (
        .clock       (clock),
        .reset       (reset),
        .squash      (squash),
        .fetch_addr  (fetch_addr),
        .load_enable (load_enable),
        .load_addr   (load_addr),
        .load_data   (load_data),
        .fetch_data  (fetch_data),
        .fetch_valid (fetch_valid)
    );

    always #2 clock = ~clock;

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    task automatic step_to_drive();
        @(posedge clock);
        #1;   // inputs change just after the edge
    endtask

    task automatic check_equal(input string name, input logic [63:0] got,
                               input logic [63:0] want);
        checks++;
        assert (got == want) else begin
            $display("FAILED %s: address %h got %h expected %h", name, fetch_addr, got, want);
            errors++;
        end
    endtask

    task automatic check_line();
        check_equal("fetch_data", fetch_data, ref_mem[fetch_addr[MEM_WORD_BITS+2:3]]);
    endtask

    // samples at the falling edge with cycle 0 as the current one
    task automatic wait_for_valid(output int cycles);
        cycles = 0;
        @(negedge clock);
        while (!fetch_valid && cycles < TIMEOUT_CYCLES) begin
            @(negedge clock);
            cycles++;
        end
        checks++;
        assert (fetch_valid) else begin
            $display("timed out after %0d cycles waiting for fetch_valid at address %h",
                     TIMEOUT_CYCLES, fetch_addr);
            errors++;
        end
    endtask

    task automatic fetch_miss(input logic [XLEN-1:0] addr);
        int cycles;
        step_to_drive();
        fetch_addr = addr;
        wait_for_valid(cycles);
        check_equal("miss latency", 64'(cycles), 64'(MISS_CYCLES));
        check_line();
    endtask

    task automatic report_test(input string name, input int errors_before);
        tests_run++;
        if (errors == errors_before) begin
            $display("%s: ok", name);
        end else begin
            $display("%s: %0d errors", name, errors - errors_before);
        end
    endtask

    task automatic preload_memory();
        logic [63:0] value;
        for (int w = 0; w < MEM_WORDS; w++) begin
            value[63:32] = lcg_next();
            value[31:0]  = lcg_next();
            step_to_drive();
            load_enable = 1'b1;
            load_addr   = MEM_WORD_BITS'(w);
            load_data   = value;
            ref_mem[load_addr] = value;
        end
        step_to_drive();
        load_enable = 1'b0;
    endtask

    task automatic reset_invalid_check();
        int errors_before;
        errors_before = errors;
        for (int i = 0; i < 64; i++) begin
            step_to_drive();
            fetch_addr = XLEN'((i + 1) * 24);   // moves every cycle so no load goes out
            @(negedge clock);
            check_equal("fetch_valid", 64'(fetch_valid), 64'(0));
        end
        report_test("reset_invalid", errors_before);
    endtask

    task automatic cold_miss_then_hit();
        int errors_before;
        errors_before = errors;
        fetch_miss(32'h0000_0010);
        for (int i = 0; i < 4; i++) begin
            @(negedge clock);
            check_equal("fetch_valid", 64'(fetch_valid), 64'(1));
        end
        step_to_drive();
        fetch_addr = 32'h0000_0014;   // same line with another byte offset
        @(negedge clock);
        check_equal("fetch_valid", 64'(fetch_valid), 64'(1));
        check_line();
        step_to_drive();
        fetch_addr = 32'h0000_0018;
        @(negedge clock);
        check_equal("fetch_valid", 64'(fetch_valid), 64'(0));
        step_to_drive();
        fetch_addr = 32'h0000_0010;
        @(negedge clock);
        check_equal("fetch_valid", 64'(fetch_valid), 64'(1));
        check_line();
        report_test("cold_miss_then_hit", errors_before);
    endtask

    task automatic conflict_eviction();
        int errors_before;
        errors_before = errors;
        fetch_miss(32'h0000_0048);   // index 9, tag 0
        fetch_miss(32'h0000_0148);   // index 9, tag 1
        fetch_miss(32'h0000_0048);
        report_test("conflict_eviction", errors_before);
    endtask

    task automatic squash_abandons_miss();
        int errors_before;
        int cycles;
        errors_before = errors;
        step_to_drive();
        fetch_addr = 32'h0000_02a0;
        for (int c = 0; c <= MISS_CYCLES; c++) begin
            squash = (c == 3);
            @(negedge clock);
            check_equal("fetch_valid", 64'(fetch_valid), 64'(0));
            step_to_drive();
        end
        wait_for_valid(cycles);
        check_line();
        report_test("squash_abandons_miss", errors_before);
    endtask

    task automatic back_pressure_refill();
        localparam int HOLD = 5;
        int          errors_before;
        int          cycles;
        logic [63:0] value;
        errors_before = errors;
        value[63:32]  = lcg_next();
        value[31:0]   = lcg_next();
        step_to_drive();
        fetch_addr = 32'h0000_03c8;
        for (int c = 0; c < HOLD; c++) begin
            if (c > 0) begin
                step_to_drive();
            end
            load_enable = 1'b1;
            load_addr   = fetch_addr[MEM_WORD_BITS+2:3];
            load_data   = value;
            ref_mem[load_addr] = value;
            @(negedge clock);
            check_equal("fetch_valid", 64'(fetch_valid), 64'(0));
        end
        step_to_drive();
        load_enable = 1'b0;
        wait_for_valid(cycles);
        // first request in cycle 1 is refused through cycle HOLD-1
        check_equal("miss latency", 64'(cycles + HOLD), 64'(MISS_CYCLES + HOLD - 1));
        check_line();
        report_test("back_pressure_refill", errors_before);
    endtask

    task automatic random_fetches();
        int errors_before;
        int cycles;
        errors_before = errors;
        for (int n = 0; n < 24; n++) begin
            step_to_drive();
            fetch_addr = lcg_next() & 32'h0000_07ff;
            wait_for_valid(cycles);
            check_line();
        end
        report_test("random_fetches", errors_before);
    endtask

    initial begin
        clock       = 1'b0;
        reset       = 1'b1;
        squash      = 1'b0;
        fetch_addr  = '0;
        load_enable = 1'b0;
        load_addr   = '0;
        load_data   = '0;
        lcg_state   = 32'h2b0a8f50;
        errors      = 0;
        checks      = 0;
        tests_run   = 0;
        repeat (8) @(posedge clock);
        #1;
        reset = 1'b0;
        preload_memory();
        reset_invalid_check();
        cold_miss_then_hit();
        conflict_eviction();
        squash_abandons_miss();
        back_pressure_refill();
        random_fetches();
        $display("tests %0d, checks %0d, errors %0d", tests_run, checks, errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/bin/sh
# build and run the icache testbench with Verilator
cd "$(dirname "$0")" || exit 1

LOG=sim.log
BUILD_DIR=obj_dir

verilator --binary --timing --assert --top-module icache_tb \
    -Mdir "$BUILD_DIR" -o icache_sim -f vlog.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

"$BUILD_DIR/icache_sim" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "FAIL: see errors above" "$LOG"; then
    exit 1
fi
exit 0

// ==== verilog/icache_array.sv ====
`timescale 1ns/1ps
`default_nettype none

module icache_array
    import icache_pkg::*;
(
    input  wire logic                        clock,
    input  wire logic                        reset,
    input  wire logic [CACHE_INDEX_BITS-1:0] index,
    input  wire logic [CACHE_TAG_BITS-1:0]   line_tag,
    input  wire logic                        fill_enable,
    input  wire logic [63:0]                 fill_data,
    output logic                             hit,
    output logic [63:0]                      line_data
);

    logic [63:0]               data  [CACHE_LINES];
    logic [CACHE_TAG_BITS-1:0] tags  [CACHE_LINES];
    logic [CACHE_LINES-1:0]    valids;

    assign hit       = valids[index] && (tags[index] == line_tag);
    assign line_data = data[index];

    // line storage
    always_ff @(posedge clock) begin
        if (fill_enable) begin
            data[index] <= fill_data;
            tags[index] <= line_tag;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            valids <= '0;   // cold cache
        end else if (fill_enable) begin
            valids[index] <= 1'b1;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/icache_miss_fsm.sv ====
`timescale 1ns/1ps
`default_nettype none

module icache_miss_fsm
    import mem_bus_pkg::*;
    import icache_pkg::*;
(
    input  wire logic                    clock,
    input  wire logic                    reset,
    input  wire logic                    squash,
    input  wire logic [XLEN-1:0]         fetch_addr,
    input  wire logic                    hit,
    input  wire logic [MEM_TAG_BITS-1:0] mem_response,
    input  wire logic [MEM_TAG_BITS-1:0] mem_tag,
    output bus_command_e                 mem_command,
    output logic [XLEN-1:0]              mem_addr,
    output logic                         fill_enable
);

    logic [CACHE_INDEX_BITS-1:0] current_index;
    logic [CACHE_INDEX_BITS-1:0] last_index;
    logic [CACHE_TAG_BITS-1:0]   current_tag;
    logic [CACHE_TAG_BITS-1:0]   last_tag;
    logic [MEM_TAG_BITS-1:0]     expected_tag;
    logic                        force_change;   // next address counts as new
    logic                        changed_addr;
    logic                        tag_match;
    miss_state_e                 state;

    assign current_index = fetch_addr[CACHE_INDEX_BITS+2:3];
    assign current_tag   = fetch_addr[CACHE_TAG_BITS+CACHE_INDEX_BITS+2:CACHE_INDEX_BITS+3];

    assign changed_addr = force_change || (current_index != last_index) ||
                          (current_tag != last_tag);
    assign tag_match    = (expected_tag != '0) && (mem_tag == expected_tag);

    // the address must be stable for a cycle before a load goes out
    assign mem_command = (state == MISS_REQUEST && !changed_addr && !squash) ?
                         BUS_LOAD : BUS_NONE;
    assign mem_addr    = {fetch_addr[XLEN-1:3], 3'b000};   // line aligned

    // never write a line under an address that just moved away
    assign fill_enable = (state == MISS_WAIT) && tag_match && !changed_addr && !squash;

    always_ff @(posedge clock) begin
        if (reset || squash) begin
            force_change <= 1'b1;
            state        <= MISS_IDLE;
            expected_tag <= '0;
        end else begin
            force_change <= 1'b0;
            last_index   <= current_index;
            last_tag     <= current_tag;

            if (changed_addr) begin
                expected_tag <= '0;   // drop any miss in flight
                state        <= hit ? MISS_IDLE : MISS_REQUEST;
            end else begin
                case (state)
                    MISS_REQUEST: begin
                        // a zero response is a refusal so ask again next cycle
                        if (mem_response != '0) begin
                            expected_tag <= mem_response;
                            state        <= MISS_WAIT;
                        end
                    end
                    MISS_WAIT: begin
                        if (fill_enable) begin
                            expected_tag <= '0;
                            state        <= MISS_IDLE;
                        end
                    end
                    default: begin
                        state <= MISS_IDLE;
                    end
                endcase
            end
        end
    end

endmodule

`default_nettype wire

// ==== verilog/icache_pkg.sv ====
`default_nettype none

package icache_pkg;

    localparam int CACHE_LINES      = 32;
    localparam int CACHE_INDEX_BITS = 5;

    // address bits 15..3 split into tag and index
    localparam int CACHE_TAG_BITS = 13 - CACHE_INDEX_BITS;

    typedef enum logic [1:0] {
        MISS_IDLE    = 2'h0,
        MISS_REQUEST = 2'h1,   // load command on the bus
        MISS_WAIT    = 2'h2    // waiting for the tagged data
    } miss_state_e;

endpackage

`default_nettype wire

// ==== verilog/icache_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module icache_top
    import mem_bus_pkg::*;
    import icache_pkg::*;
(
    input  wire logic                     clock,
    input  wire logic                     reset,
    input  wire logic                     squash,
    input  wire logic [XLEN-1:0]          fetch_addr,
    input  wire logic                     load_enable,
    input  wire logic [MEM_WORD_BITS-1:0] load_addr,
    input  wire logic [63:0]              load_data,
    output logic [63:0]                   fetch_data,
    output logic                          fetch_valid
);

    bus_command_e             mem_command;
    logic [XLEN-1:0]          mem_addr;
    logic [MEM_TAG_BITS-1:0]  mem_response;
    logic [MEM_TAG_BITS-1:0]  mem_tag;
    logic [63:0]              mem_data;
    logic [MEM_WORD_BITS-1:0] read_addr;
    logic [63:0]              read_data;
    logic                     hit;
    logic                     fill_enable;

    icache_array icache_array_inst (
        .clock       (clock),
        .reset       (reset),
        .index       (fetch_addr[CACHE_INDEX_BITS+2:3]),
        .line_tag    (fetch_addr[CACHE_TAG_BITS+CACHE_INDEX_BITS+2:CACHE_INDEX_BITS+3]),
        .fill_enable (fill_enable),
        .fill_data   (mem_data),
        .hit         (hit),
        .line_data   (fetch_data)
    );

    icache_miss_fsm icache_miss_fsm_inst (
        .clock        (clock),
        .reset        (reset),
        .squash       (squash),
        .fetch_addr   (fetch_addr),
        .hit          (hit),
        .mem_response (mem_response),
        .mem_tag      (mem_tag),
        .mem_command  (mem_command),
        .mem_addr     (mem_addr),
        .fill_enable  (fill_enable)
    );

    mem_latency_timer mem_latency_timer_inst (
        .clock        (clock),
        .reset        (reset),
        .mem_command  (mem_command),
        .mem_addr     (mem_addr),
        .load_enable  (load_enable),
        .mem_response (mem_response),
        .read_addr    (read_addr),
        .read_data    (read_data),
        .mem_tag      (mem_tag),
        .mem_data     (mem_data)
    );

    imem_backing imem_backing_inst (
        .clock       (clock),
        .load_enable (load_enable),
        .load_addr   (load_addr),
        .load_data   (load_data),
        .read_addr   (read_addr),
        .read_data   (read_data)
    );

    assign fetch_valid = hit;   // a hit is a valid fetch

endmodule

`default_nettype wire

// ==== verilog/imem_backing.sv ====
`timescale 1ns/1ps
`default_nettype none

module imem_backing
    import mem_bus_pkg::*;
(
    input  wire logic                     clock,
    input  wire logic                     load_enable,
    input  wire logic [MEM_WORD_BITS-1:0] load_addr,
    input  wire logic [63:0]              load_data,
    input  wire logic [MEM_WORD_BITS-1:0] read_addr,
    output logic [63:0]                   read_data
);

    logic [63:0] words [MEM_WORDS];

    // preload port
    always_ff @(posedge clock) begin
        if (load_enable) begin
            words[load_addr] <= load_data;
        end
    end

    assign read_data = words[read_addr];   // combinational read

endmodule

`default_nettype wire

// ==== verilog/mem_bus_pkg.sv ====
`default_nettype none

package mem_bus_pkg;

    // commands the cache can place on the memory bus
    typedef enum logic [1:0] {
        BUS_NONE = 2'h0,
        BUS_LOAD = 2'h1
    } bus_command_e;

    localparam int XLEN = 32;               // fetch address width

    // a zero tag means no transaction
    localparam int MEM_TAG_BITS = 4;

    localparam int MEM_WORDS          = 256;   // 64-bit words in the backing store
    localparam int MEM_WORD_BITS      = 8;
    localparam int MEM_LATENCY_CYCLES = 6;     // acceptance to data strobe

endpackage

`default_nettype wire

// ==== verilog/mem_latency_timer.sv ====
`timescale 1ns/1ps
`default_nettype none

module mem_latency_timer
    import mem_bus_pkg::*;
(
    input  wire logic                     clock,
    input  wire logic                     reset,
    input  wire bus_command_e             mem_command,
    input  wire logic [XLEN-1:0]          mem_addr,
    input  wire logic                     load_enable,
    output logic [MEM_TAG_BITS-1:0]       mem_response,
    output logic [MEM_WORD_BITS-1:0]      read_addr,
    input  wire logic [63:0]              read_data,
    output logic [MEM_TAG_BITS-1:0]       mem_tag,
    output logic [63:0]                   mem_data
);

    logic [MEM_TAG_BITS-1:0]  next_tag;
    logic                     accept;
    logic [MEM_TAG_BITS-1:0]  tag_pipe  [MEM_LATENCY_CYCLES];
    logic [MEM_WORD_BITS-1:0] addr_pipe [MEM_LATENCY_CYCLES];

    // preload writes hold off every new load
    assign accept       = (mem_command == BUS_LOAD) && !load_enable;
    assign mem_response = accept ? next_tag : '0;

    assign read_addr = addr_pipe[MEM_LATENCY_CYCLES-1];
    assign mem_tag   = tag_pipe[MEM_LATENCY_CYCLES-1];
    assign mem_data  = read_data;   // word is read as it leaves the pipe

    always_ff @(posedge clock) begin
        if (reset) begin
            next_tag <= MEM_TAG_BITS'(1);
        end else if (accept) begin
            next_tag <= (next_tag == '1) ? MEM_TAG_BITS'(1) : next_tag + 1'b1;   // skip zero
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < MEM_LATENCY_CYCLES; i++) begin
                tag_pipe[i] <= '0;
            end
        end else begin
            tag_pipe[0] <= mem_response;
            for (int i = 1; i < MEM_LATENCY_CYCLES; i++) begin
                tag_pipe[i] <= tag_pipe[i-1];
            end
        end
    end

    always_ff @(posedge clock) begin
        addr_pipe[0] <= mem_addr[MEM_WORD_BITS+2:3];   // higher bits ignored
        for (int i = 1; i < MEM_LATENCY_CYCLES; i++) begin
            addr_pipe[i] <= addr_pipe[i-1];
        end
    end

endmodule

`default_nettype wire

// ==== vlog.f ====
verilog/mem_bus_pkg.sv
verilog/icache_pkg.sv
verilog/icache_array.sv
verilog/icache_miss_fsm.sv
verilog/mem_latency_timer.sv
verilog/imem_backing.sv
verilog/icache_top.sv
dv/icache_tb.sv
